// ==== include/ffcp_settings.svh ====
// Widths, sizes and protocol codes of the FFCP receive path, included by the package and the testbench
`ifndef FFCP_SETTINGS_SVH
`define FFCP_SETTINGS_SVH

// Byte and payload geometry
`define FFCP_BYTE_LEN 8
`define FFCP_FGP_LEN 16
`define FFCP_COUNT_LEN 4

// Slots, also the depth of the commit FIFO
`define FFCP_SLOT_COUNT 4
`define FFCP_INDEX_LEN 2

// Buffer address is slot index followed by byte count
`define FFCP_ADDR_LEN 6

// Ethertype carried by every FFCP frame
`define FFCP_ETHERTYPE 16'h88b5

// FFCP type byte codes
`define FFCP_TYPE_SYN 8'h01
`define FFCP_TYPE_MSG 8'h02
`define FFCP_TYPE_ACK 8'h04

`endif

// ==== hdl/ffcp_pkg.sv ====
// Shared types of the FFCP receive path, imported by every module of the design and by the testbench
package ffcp_pkg;

`include "ffcp_settings.svh"

	typedef logic [`FFCP_BYTE_LEN-1:0] byte_t;
	typedef logic [`FFCP_INDEX_LEN-1:0] slot_index_t;
	typedef logic [`FFCP_COUNT_LEN-1:0] byte_count_t;
	typedef logic [`FFCP_ADDR_LEN-1:0] buf_addr_t;

	typedef enum logic [`FFCP_BYTE_LEN-1:0] {
		FFCP_SYN = `FFCP_TYPE_SYN,
		FFCP_MSG = `FFCP_TYPE_MSG,
		FFCP_ACK = `FFCP_TYPE_ACK
	} ffcp_type_t;

	// One byte from the MAC receiver, no back-pressure
	typedef struct packed {
		logic valid;
		byte_t data;
		logic last;
		logic err;
	} frame_byte_t;

	typedef struct packed {
		logic en;
		buf_addr_t addr;
		byte_t data;
	} buf_write_t;

	typedef enum logic [2:0] {
		ETH_HI,
		ETH_LO,
		TYPE,
		INDEX,
		PAYLOAD,
		DISCARD
	} parser_state_t;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		ACK
	} stream_state_t;

endpackage

// ==== hdl/ffcp_frame_parser.sv ====
// Frame parser that checks FFCP headers, writes MSG payloads into buffer slots and commits clean frames
`timescale 1ns/100ps
`include "ffcp_settings.svh"

module ffcp_frame_parser (
	input  logic                  clk,
	input  logic                  eth_rx_downstream_rst,
	input  ffcp_pkg::frame_byte_t rx_in,
	input  logic                  commit_full,
	output ffcp_pkg::buf_write_t  buf_wr,
	output logic                  commit_valid,
	output ffcp_pkg::slot_index_t commit_index
);
	import ffcp_pkg::*;

	localparam logic [2*`FFCP_BYTE_LEN-1:0] ETHERTYPE = `FFCP_ETHERTYPE;
	localparam byte_count_t LAST_POS = byte_count_t'(`FFCP_FGP_LEN - 1);

	parser_state_t state;
	parser_state_t drop_state;
	byte_count_t cnt;
	slot_index_t idx;
	logic hdr_ok;
	logic hdr_pass;
	logic cnt_final;
	logic wr_en;
	buf_addr_t wr_addr;
	byte_t wr_data;

	// Header byte check for the current state
	always_comb begin
		hdr_ok = 1'b0;
		case (state)
			ETH_HI: hdr_ok = rx_in.data == ETHERTYPE[2*`FFCP_BYTE_LEN-1:`FFCP_BYTE_LEN];
			ETH_LO: hdr_ok = rx_in.data == ETHERTYPE[`FFCP_BYTE_LEN-1:0];
			TYPE: hdr_ok = rx_in.data == FFCP_MSG;
			INDEX: hdr_ok = (rx_in.data < `FFCP_SLOT_COUNT) && !commit_full;
			default: hdr_ok = 1'b0;
		endcase
	end

	assign hdr_pass = hdr_ok && !rx_in.err && !rx_in.last;
	assign cnt_final = cnt == LAST_POS;

	// A rejected frame may already be over on this byte
	assign drop_state = rx_in.last ? ETH_HI : DISCARD;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= ETH_HI;
			cnt <= '0;
			wr_en <= 1'b0;
			commit_valid <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			commit_valid <= 1'b0;
			if (rx_in.valid) begin
				case (state)
					ETH_HI: state <= hdr_pass ? ETH_LO : drop_state;
					ETH_LO: state <= hdr_pass ? TYPE : drop_state;
					TYPE: state <= hdr_pass ? INDEX : drop_state;
					INDEX: begin
						state <= hdr_pass ? PAYLOAD : drop_state;
						cnt <= '0;
					end
					PAYLOAD: begin
						// Early last or missing last both condemn the frame
						if (rx_in.err || (rx_in.last != cnt_final)) begin
							state <= drop_state;
						end else begin
							wr_en <= 1'b1;
							cnt <= cnt + 1'b1;
							if (cnt_final) begin
								commit_valid <= 1'b1;
								state <= ETH_HI;
							end
						end
					end
					DISCARD: begin
						if (rx_in.last) begin
							state <= ETH_HI;
						end
					end
					default: state <= ETH_HI;
				endcase
			end
		end
	end

	// Slot index and write payload
	always_ff @(posedge clk) begin
		if (rx_in.valid && state == INDEX) begin
			idx <= rx_in.data[`FFCP_INDEX_LEN-1:0];
		end
		if (rx_in.valid && state == PAYLOAD) begin
			wr_addr <= {idx, cnt};
			wr_data <= rx_in.data;
		end
	end

	assign buf_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

	// idx holds until the next index byte, well after the commit pulse
	assign commit_index = idx;

	// Full was low at the index byte and only this parser pushes
	commit_not_full_a: assert property (
		@(posedge clk) disable iff (eth_rx_downstream_rst)
		!(commit_valid && commit_full)
	);

endmodule

// ==== hdl/packet_buffer.sv ====
// Packet buffer with one slot of RAM per FFCP index and a FIFO of committed slots for the streamer
`timescale 1ns/100ps
`include "ffcp_settings.svh"

module packet_buffer (
	input  logic                  clk,
	input  logic                  eth_rx_downstream_rst,
	input  ffcp_pkg::buf_write_t  buf_wr,
	input  logic                  commit_valid,
	input  ffcp_pkg::slot_index_t commit_index,
	output logic                  commit_full,
	input  logic                  rd_en,
	input  ffcp_pkg::buf_addr_t   rd_addr,
	output ffcp_pkg::byte_t       rd_data,
	output logic                  pending,
	output ffcp_pkg::slot_index_t head_index,
	input  logic                  pop
);
	import ffcp_pkg::*;

	byte_t ram [`FFCP_SLOT_COUNT*`FFCP_FGP_LEN];

	slot_index_t fifo [`FFCP_SLOT_COUNT];
	slot_index_t wr_ptr;
	slot_index_t rd_ptr;
	logic [`FFCP_INDEX_LEN:0] fill_cnt;
	logic push_ok;
	logic pop_ok;

	// Slot RAM, registered read port
	always_ff @(posedge clk) begin
		if (buf_wr.en) begin
			ram[buf_wr.addr] <= buf_wr.data;
		end
		if (rd_en) begin
			rd_data <= ram[rd_addr];
		end
	end

	assign commit_full = fill_cnt == `FFCP_SLOT_COUNT;
	assign pending = fill_cnt != '0;
	assign head_index = fifo[rd_ptr];

	assign push_ok = commit_valid && !commit_full;
	assign pop_ok = pop && pending;

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill_cnt <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10: fill_cnt <= fill_cnt + 1'b1;
				2'b01: fill_cnt <= fill_cnt - 1'b1;
				default: fill_cnt <= fill_cnt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push_ok) begin
			fifo[wr_ptr] <= commit_index;
		end
	end

	no_push_when_full_a: assert property (
		@(posedge clk) disable iff (eth_rx_downstream_rst)
		commit_valid |-> !commit_full
	);

	no_pop_when_empty_a: assert property (
		@(posedge clk) disable iff (eth_rx_downstream_rst)
		pop |-> pending
	);

endmodule

// ==== hdl/slot_streamer.sv ====
// Slot streamer that reads committed slots out as a valid/ready byte stream and acknowledges each one
`timescale 1ns/100ps
`include "ffcp_settings.svh"

module slot_streamer (
	input  logic                  clk,
	input  logic                  eth_rx_downstream_rst,
	input  logic                  pending,
	input  ffcp_pkg::slot_index_t head_index,
	output logic                  pop,
	output logic                  rd_en,
	output ffcp_pkg::buf_addr_t   rd_addr,
	input  ffcp_pkg::byte_t       rd_data,
	input  logic                  out_ready,
	output logic                  out_valid,
	output ffcp_pkg::byte_t       out_data,
	output logic                  out_last,
	output logic                  ack_valid,
	output ffcp_pkg::slot_index_t ack_index
);
	import ffcp_pkg::*;

	localparam byte_count_t LAST_POS = byte_count_t'(`FFCP_FGP_LEN - 1);

	stream_state_t state;
	slot_index_t cur_index;
	byte_count_t rd_cnt;
	logic rd_done;
	logic rd_pend;
	logic rd_last_pend;
	logic [1:0] fill;
	logic [1:0] occupancy;
	logic out_fire;
	byte_t skid_data [2];
	logic skid_last [2];

	assign pop = state == IDLE && pending;
	assign out_fire = out_valid && out_ready;

	// Skid entries plus the read in flight never exceed two
	assign occupancy = fill + {1'b0, rd_pend};
	assign rd_en = state == READ && !rd_done && (occupancy != 2'd2 || out_fire);
	assign rd_addr = {cur_index, rd_cnt};

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= IDLE;
			rd_cnt <= '0;
			rd_done <= 1'b0;
			rd_pend <= 1'b0;
			rd_last_pend <= 1'b0;
		end else begin
			rd_pend <= rd_en;
			rd_last_pend <= rd_en && rd_cnt == LAST_POS;
			case (state)
				IDLE: begin
					if (pending) begin
						state <= READ;
						rd_cnt <= '0;
						rd_done <= 1'b0;
					end
				end
				READ: begin
					if (rd_en) begin
						rd_cnt <= rd_cnt + 1'b1;
						rd_done <= rd_cnt == LAST_POS;
					end
					if (out_fire && out_last) begin
						state <= ACK;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cur_index <= head_index;
		end
	end

	// Two-entry skid FIFO, entry 0 drives the output
	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			fill <= '0;
		end else begin
			fill <= fill + {1'b0, rd_pend} - {1'b0, out_fire};
		end
	end

	always_ff @(posedge clk) begin
		if (out_fire) begin
			skid_data[0] <= skid_data[1];
			skid_last[0] <= skid_last[1];
		end
		if (rd_pend) begin
			if (fill == 2'd0 || (fill == 2'd1 && out_fire)) begin
				skid_data[0] <= rd_data;
				skid_last[0] <= rd_last_pend;
			end else begin
				skid_data[1] <= rd_data;
				skid_last[1] <= rd_last_pend;
			end
		end
	end

	assign out_valid = fill != 2'd0;
	assign out_data = skid_data[0];
	assign out_last = skid_last[0];

	assign ack_valid = state == ACK;
	assign ack_index = cur_index;

	out_hold_a: assert property (
		@(posedge clk) disable iff (eth_rx_downstream_rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last)
	);

endmodule

// ==== hdl/ffcp_rx_top.sv ====
// Top level of the FFCP receive path, connecting parser, packet buffer and slot streamer
`timescale 1ns/100ps

module ffcp_rx_top (
	input  logic                  clk,
	input  logic                  eth_rx_downstream_rst,
	input  ffcp_pkg::frame_byte_t rx_in,
	input  logic                  out_ready,
	output logic                  out_valid,
	output ffcp_pkg::byte_t       out_data,
	output logic                  out_last,
	output logic                  ack_valid,
	output ffcp_pkg::slot_index_t ack_index
);
	import ffcp_pkg::*;

	buf_write_t buf_wr;
	logic commit_valid;
	slot_index_t commit_index;
	logic commit_full;
	logic rd_en;
	buf_addr_t rd_addr;
	byte_t rd_data;
	logic pending;
	slot_index_t head_index;
	logic pop;

	ffcp_frame_parser parser_inst (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rx_in(rx_in), .commit_full(commit_full),
		.buf_wr(buf_wr),
		.commit_valid(commit_valid), .commit_index(commit_index)
	);

	packet_buffer buffer_inst (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.buf_wr(buf_wr),
		.commit_valid(commit_valid), .commit_index(commit_index),
		.commit_full(commit_full),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.pending(pending), .head_index(head_index), .pop(pop)
	);

	slot_streamer streamer_inst (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.pending(pending), .head_index(head_index), .pop(pop),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.out_ready(out_ready), .out_valid(out_valid),
		.out_data(out_data), .out_last(out_last),
		.ack_valid(ack_valid), .ack_index(ack_index)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset source, a 10 ns clock with reset held high for the first five cycles
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic eth_rx_downstream_rst
);
	localparam real HALF_PERIOD = 5.0;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Released just after the fifth rising edge
	initial begin
		eth_rx_downstream_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		eth_rx_downstream_rst = 1'b0;
	end

endmodule

// ==== dv/ffcp_rx_tb.sv ====
// Testbench for the FFCP receive path, sends random good and broken frames and checks the output
`timescale 1ns/100ps
`include "ffcp_settings.svh"

module ffcp_rx_tb;
	import ffcp_pkg::*;

	localparam int SLOTS = `FFCP_SLOT_COUNT;
	localparam int FGP = `FFCP_FGP_LEN;
	localparam int HDR = 4;

	// Frame kinds
	localparam int K_GOOD = 0;
	localparam int K_BAD_ETH = 1;
	localparam int K_SYN = 2;
	localparam int K_ACK = 3;
	localparam int K_ERR = 4;
	localparam int K_EARLY = 5;
	localparam int K_LONG = 6;

	localparam int N_QUIET = 4;
	localparam int N_GOOD = 12;
	localparam int N_ETH = 6;
	localparam int N_TYPE = 8;
	localparam int N_BROKEN = 12;
	localparam int N_BP = 16;
	localparam int N_MIXED = 16;
	localparam int FRAME_COUNT = N_QUIET + N_GOOD + N_ETH + N_TYPE + N_BROKEN + N_BP + N_MIXED;
	localparam int WATCHDOG_CYCLES = FRAME_COUNT * 40 + 1000;

	logic clk;
	logic eth_rx_downstream_rst;
	frame_byte_t rx_in;
	logic out_ready;
	logic out_valid;
	byte_t out_data;
	logic out_last;
	logic ack_valid;
	slot_index_t ack_index;

	integer seed = 23;
	integer ready_seed = 23;
	int stall_pct = 0;
	string cur_test = "reset";

	// Reference model
	byte_t exp_bytes[$];
	slot_index_t exp_index[$];
	logic in_use [SLOTS];
	int byte_pos = 0;
	logic ack_due = 1'b0;
	slot_index_t ack_idx_due;
	logic hold_valid = 1'b0;
	byte_t hold_data;
	logic hold_last;

	tb_clock_gen clock_gen (
		.clk(clk),
		.eth_rx_downstream_rst(eth_rx_downstream_rst)
	);

	ffcp_rx_top dut (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rx_in(rx_in), .out_ready(out_ready),
		.out_valid(out_valid), .out_data(out_data), .out_last(out_last),
		.ack_valid(ack_valid), .ack_index(ack_index)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_byte(input string what, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			fail_run($sformatf("FAILED %s %s: expected 8'h%02h, actual 8'h%02h",
				cur_test, what, exp, act));
		end
	endtask

	task automatic check_index(input string what, input slot_index_t exp, input slot_index_t act);
		if (act !== exp) begin
			fail_run($sformatf("FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act));
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act));
		end
	endtask

	task automatic rand_below(input int limit, output int val);
		val = $unsigned($random(seed)) % limit;
	endtask

	// One input byte, sometimes after an idle cycle
	task automatic drive_byte(input byte_t data, input logic last, input logic err);
		int gap;
		rand_below(8, gap);
		if (gap == 0) begin
			@(posedge clk);
			#1;
			rx_in = '0;
		end
		@(posedge clk);
		#1;
		rx_in = '{valid: 1'b1, data: data, last: last, err: err};
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#1;
		rx_in = '0;
	endtask

	// Waits until some index has been acknowledged
	task automatic pick_free_index(output slot_index_t idx);
		int start;
		int found;
		found = -1;
		while (found < 0) begin
			rand_below(SLOTS, start);
			for (int k = 0; k < SLOTS; k++) begin
				if (found < 0 && !in_use[(start + k) % SLOTS]) begin
					found = (start + k) % SLOTS;
				end
			end
			if (found < 0) begin
				@(posedge clk);
				#1;
			end
		end
		idx = slot_index_t'(found);
	endtask

	task automatic send_frame(input int kind);
		byte_t fb[$];
		slot_index_t idx;
		logic [15:0] eth;
		byte_t ftype;
		int val;
		int err_pos;
		pick_free_index(idx);
		eth = `FFCP_ETHERTYPE;
		ftype = `FFCP_TYPE_MSG;
		if (kind == K_BAD_ETH) begin
			rand_below(16, val);
			eth = eth ^ (16'h0001 << val);
		end
		if (kind == K_SYN) begin
			ftype = `FFCP_TYPE_SYN;
		end
		if (kind == K_ACK) begin
			ftype = `FFCP_TYPE_ACK;
		end
		fb = {eth[15:8], eth[7:0], ftype, byte_t'(idx)};
		for (int i = 0; i < FGP; i++) begin
			fb.push_back(byte_t'($random(seed)));
		end
		if (kind == K_LONG) begin
			rand_below(3, val);
			for (int i = 0; i <= val; i++) begin
				fb.push_back(byte_t'($random(seed)));
			end
		end
		if (kind == K_EARLY) begin
			rand_below(HDR + FGP - 1, val);
			while (fb.size() > val + 1) begin
				void'(fb.pop_back());
			end
		end
		err_pos = -1;
		if (kind == K_ERR) begin
			rand_below(fb.size(), err_pos);
		end
		if (kind == K_GOOD) begin
			in_use[idx] = 1'b1;
			exp_index.push_back(idx);
			for (int i = HDR; i < HDR + FGP; i++) begin
				exp_bytes.push_back(fb[i]);
			end
		end
		for (int i = 0; i < fb.size(); i++) begin
			drive_byte(fb[i], i == fb.size() - 1, i == err_pos);
		end
		drive_idle();
	endtask

	// Back-pressure on the output stream
	initial begin
		out_ready = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			out_ready = ($unsigned($random(ready_seed)) % 100) >= stall_pct;
		end
	end

	always @(posedge clk) begin : monitor
		byte_t exp_b;
		if (eth_rx_downstream_rst === 1'b0) begin
			if (hold_valid) begin
				if (out_valid !== 1'b1) begin
					fail_run("out_valid dropped while a byte was held by back-pressure");
				end
				check_byte("held data", hold_data, out_data);
				check_flag("held last", hold_last, out_last);
			end
			if (ack_due) begin
				if (ack_valid !== 1'b1) begin
					fail_run("no acknowledge in the cycle after the final byte of a slot");
				end
				check_index("ack index", ack_idx_due, ack_index);
				in_use[ack_idx_due] = 1'b0;
				ack_due = 1'b0;
			end else if (ack_valid !== 1'b0) begin
				fail_run("acknowledge seen with no finished slot");
			end
			hold_valid = 1'b0;
			if (out_valid !== 1'b0) begin
				if (exp_bytes.size() == 0) begin
					fail_run("output valid while no good frame is expected");
				end
				if (out_ready) begin
					exp_b = exp_bytes.pop_front();
					check_byte($sformatf("byte %0d", byte_pos), exp_b, out_data);
					check_flag($sformatf("last on byte %0d", byte_pos), byte_pos == FGP - 1, out_last);
					if (byte_pos == FGP - 1) begin
						ack_due = 1'b1;
						ack_idx_due = exp_index.pop_front();
						byte_pos = 0;
					end else begin
						byte_pos++;
					end
				end else begin
					hold_valid = 1'b1;
					hold_data = out_data;
					hold_last = out_last;
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		fail_run($sformatf("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		int kind;
		rx_in = '0;
		for (int i = 0; i < SLOTS; i++) begin
			in_use[i] = 1'b0;
		end
		wait (eth_rx_downstream_rst === 1'b1);
		wait (eth_rx_downstream_rst === 1'b0);

		// Nothing may come out before the first good frame
		cur_test = "quiet_start";
		for (int i = 0; i < N_QUIET; i++) begin
			rand_below(6, kind);
			send_frame(K_BAD_ETH + kind);
		end

		cur_test = "good_frames";
		for (int i = 0; i < N_GOOD; i++) begin
			send_frame(K_GOOD);
		end

		cur_test = "bad_ethertype";
		for (int i = 0; i < N_ETH; i++) begin
			send_frame(i % 2 ? K_GOOD : K_BAD_ETH);
		end

		cur_test = "wrong_type";
		for (int i = 0; i < N_TYPE; i++) begin
			send_frame(i % 2 ? K_GOOD : (i % 4 == 0 ? K_SYN : K_ACK));
		end

		cur_test = "broken_frames";
		for (int i = 0; i < N_BROKEN; i++) begin
			rand_below(3, kind);
			send_frame(i % 2 ? K_GOOD : K_ERR + kind);
		end

		cur_test = "backpressure";
		stall_pct = 40;
		for (int i = 0; i < N_BP; i++) begin
			send_frame(K_GOOD);
		end

		cur_test = "mixed";
		stall_pct = 25;
		for (int i = 0; i < N_MIXED; i++) begin
			rand_below(7, kind);
			send_frame(kind);
		end

		// Drain, then idle to catch stray output
		while (exp_bytes.size() != 0 || ack_due) begin
			@(posedge clk);
		end
		repeat (50) @(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
hdl/ffcp_pkg.sv
hdl/ffcp_frame_parser.sv
hdl/packet_buffer.sv
hdl/slot_streamer.sv
hdl/ffcp_rx_top.sv
dv/tb_clock_gen.sv
dv/ffcp_rx_tb.sv

// ==== Bender.yml ====
package:
  name: ffcp_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/ffcp_pkg.sv
      - hdl/ffcp_frame_parser.sv
      - hdl/packet_buffer.sv
      - hdl/slot_streamer.sv
      - hdl/ffcp_rx_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tb_clock_gen.sv
      - dv/ffcp_rx_tb.sv
